// File: hdl/opq_cfg.svh
`ifndef OPQ_CFG_SVH
`define OPQ_CFG_SVH

////////////////////////////////////////////////////////////
// Operand queue configuration

// Operand word width in bits
`define OPQ_ELEN 64

// Entries in both the command and the operand buffer
`define OPQ_BUF_DEPTH 2

// Width of the vector length and of the element counter
`define OPQ_VL_W 16

`endif

// File: hdl/opq_pkg.sv
`include "opq_cfg.svh"

package opq_pkg;

  // Source element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Integer conversion applied on the way out
  typedef enum logic [2:0] {
    CONV_NONE = 3'd0,
    SEXT2     = 3'd1,
    SEXT4     = 3'd2,
    SEXT8     = 3'd3,
    ZEXT2     = 3'd4,
    ZEXT4     = 3'd5,
    ZEXT8     = 3'd6
  } conv_e;

  typedef logic [`OPQ_ELEN-1:0] elen_t;

  typedef struct packed {
    eew_e                 eew;
    conv_e                conv;
    logic [`OPQ_VL_W-1:0] vl;
  } opq_cmd_t;

endpackage

// File: hdl/opq_fifo.sv
`timescale 1ns/1ps
`include "opq_cfg.svh"

module opq_fifo #(
  parameter type         payload_t = logic [`OPQ_ELEN-1:0],
  parameter int unsigned DEPTH     = `OPQ_BUF_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Head is visible without a pop
  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("opq_fifo: push while full");
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("opq_fifo: pop while empty");

endmodule

// File: hdl/opq_cmd_decode.sv
`timescale 1ns/1ps
`include "opq_cfg.svh"

module opq_cmd_decode (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  opq_pkg::opq_cmd_t    cmd_i,
  input  logic                 cmd_valid_i,
  input  logic                 cmd_pop_i,
  output logic                 cmd_ready_o,
  output logic                 head_valid_o,
  output opq_pkg::eew_e        eew_o,
  output logic                 is_signed_o,
  output logic [1:0]           widen_log_o,
  output logic [`OPQ_VL_W-1:0] vl_o
);

  opq_pkg::opq_cmd_t cmd_head;
  logic              cmd_full;
  logic              cmd_empty;
  logic              cmd_push;
  logic [1:0]        in_widen_log;
  logic [2:0]        in_width_log;

  // log2 of the widening factor
  function automatic logic [1:0] widen_log_of(opq_pkg::conv_e conv);
    case (conv)
      opq_pkg::SEXT2, opq_pkg::ZEXT2: return 2'd1;
      opq_pkg::SEXT4, opq_pkg::ZEXT4: return 2'd2;
      opq_pkg::SEXT8, opq_pkg::ZEXT8: return 2'd3;
      default:                        return 2'd0;
    endcase
  endfunction

  assign cmd_ready_o = !cmd_full;
  assign cmd_push    = cmd_valid_i && cmd_ready_o;

  opq_fifo #(
    .payload_t(opq_pkg::opq_cmd_t),
    .DEPTH    (`OPQ_BUF_DEPTH)
  ) i_cmd_buf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_push),
    .data_i (cmd_i),
    .pop_i  (cmd_pop_i),
    .data_o (cmd_head),
    .full_o (cmd_full),
    .empty_o(cmd_empty)
  );

  ////////////////////////////////////////////////////////////
  // Head command decode
  assign head_valid_o = !cmd_empty;
  assign eew_o        = cmd_head.eew;
  assign vl_o         = cmd_head.vl;
  assign widen_log_o  = widen_log_of(cmd_head.conv);
  assign is_signed_o  = cmd_head.conv inside {opq_pkg::SEXT2, opq_pkg::SEXT4, opq_pkg::SEXT8};

  // Widened element must still fit in one operand word
  assign in_widen_log = widen_log_of(cmd_i.conv);
  assign in_width_log = {1'b0, cmd_i.eew} + {1'b0, in_widen_log};

  a_cmd_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_push |-> (in_width_log <= 3'd3) && (cmd_i.vl != '0))
    else $error("opq_cmd_decode: illegal command accepted");

endmodule

// File: hdl/opq_widen_exec.sv
`timescale 1ns/1ps
`include "opq_cfg.svh"

module opq_widen_exec (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  opq_pkg::elen_t operand_i,
  input  logic           operand_valid_i,
  input  logic           word_pop_i,
  input  opq_pkg::eew_e  eew_i,
  input  logic           is_signed_i,
  input  logic [1:0]     widen_log_i,
  input  logic [2:0]     select_i,
  output logic           word_valid_o,
  output opq_pkg::elen_t widened_o
);

  opq_pkg::elen_t ibuf_data;
  opq_pkg::elen_t src;
  logic           ibuf_full;
  logic           ibuf_empty;
  logic [5:0]     shift_amt;

  opq_fifo #(
    .payload_t(opq_pkg::elen_t),
    .DEPTH    (`OPQ_BUF_DEPTH)
  ) i_operand_buf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (word_pop_i),
    .data_o (ibuf_data),
    .full_o (ibuf_full),
    .empty_o(ibuf_empty)
  );

  assign word_valid_o = !ibuf_empty;

  ////////////////////////////////////////////////////////////
  // Widening datapath
  // Select picks the 64/F bit slice that feeds this beat
  assign shift_amt = 6'(select_i) << (3'd6 - {1'b0, widen_log_i});
  assign src       = ibuf_data >> shift_amt;

  always_comb begin
    widened_o = ibuf_data;
    case (widen_log_i)
      2'd1: begin
        case (eew_i)
          opq_pkg::EW8: begin
            for (int e = 0; e < 4; e++) begin
              widened_o[16*e +: 16] = {{8{is_signed_i & src[8*e+7]}}, src[8*e +: 8]};
            end
          end
          opq_pkg::EW16: begin
            for (int e = 0; e < 2; e++) begin
              widened_o[32*e +: 32] = {{16{is_signed_i & src[16*e+15]}}, src[16*e +: 16]};
            end
          end
          opq_pkg::EW32: widened_o = {{32{is_signed_i & src[31]}}, src[31:0]};
          default: ;
        endcase
      end
      2'd2: begin
        case (eew_i)
          opq_pkg::EW8: begin
            for (int e = 0; e < 2; e++) begin
              widened_o[32*e +: 32] = {{24{is_signed_i & src[8*e+7]}}, src[8*e +: 8]};
            end
          end
          opq_pkg::EW16: widened_o = {{48{is_signed_i & src[15]}}, src[15:0]};
          default: ;
        endcase
      end
      2'd3: begin
        if (eew_i == opq_pkg::EW8) begin
          widened_o = {{56{is_signed_i & src[7]}}, src[7:0]};
        end
      end
      // No widening, word passes as is
      default: ;
    endcase
  end

  // Credits upstream must keep data from landing on a full buffer
  a_no_data_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_i |-> !ibuf_full)
    else $error("opq_widen_exec: operand arrived with buffer full");

endmodule

// File: hdl/opq_result.sv
`timescale 1ns/1ps
`include "opq_cfg.svh"

module opq_result (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 operand_issued_i,
  input  logic                 head_valid_i,
  input  logic                 word_valid_i,
  input  opq_pkg::elen_t       widened_i,
  input  opq_pkg::eew_e        eew_i,
  input  logic [1:0]           widen_log_i,
  input  logic [`OPQ_VL_W-1:0] vl_i,
  input  logic                 operand_ready_i,
  output logic                 operand_queue_ready_o,
  output opq_pkg::elen_t       operand_o,
  output logic                 operand_valid_o,
  output logic                 cmd_pop_o,
  output logic                 word_pop_o,
  output logic [2:0]           select_o
);

  localparam int unsigned CRD_W = $clog2(`OPQ_BUF_DEPTH + 1);
  localparam int unsigned CNT_W = `OPQ_VL_W + 1;

  logic [`OPQ_VL_W-1:0] elem_cnt_q;
  logic [CNT_W-1:0]     elem_next;
  logic [2:0]           select_q;
  logic [2:0]           select_next;
  logic [2:0]           select_mask;
  logic [2:0]           width_log;
  logic [3:0]           elems_per_beat;
  logic [CRD_W-1:0]     credit_q;
  logic                 fire;
  logic                 last_beat;

  assign operand_o       = widened_i;
  assign operand_valid_o = head_valid_i && word_valid_i;
  assign fire            = operand_valid_o && operand_ready_i;

  ////////////////////////////////////////////////////////////
  // Element and select counting
  // Output elements per beat is 8 bytes over W*F bytes
  assign width_log      = {1'b0, eew_i} + {1'b0, widen_log_i};
  assign elems_per_beat = 4'd8 >> width_log;
  assign elem_next      = {1'b0, elem_cnt_q} + CNT_W'(elems_per_beat);
  assign last_beat      = (elem_next >= {1'b0, vl_i});

  // Select runs modulo F; a zero mask means every beat takes a new word
  assign select_mask = (3'd1 << widen_log_i) - 3'd1;
  assign select_next = (select_q + 3'd1) & select_mask;
  assign select_o    = select_q;

  assign cmd_pop_o  = fire && last_beat;
  assign word_pop_o = fire && (last_beat || (select_next == '0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_cnt_q <= '0;
      select_q   <= '0;
    end else if (fire) begin
      if (last_beat) begin
        elem_cnt_q <= '0;
        select_q   <= '0;
      end else begin
        elem_cnt_q <= elem_next[`OPQ_VL_W-1:0];
        select_q   <= select_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Input credits
  // Promised words count until the word leaves the buffer
  assign operand_queue_ready_o = (credit_q < CRD_W'(`OPQ_BUF_DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_q + CRD_W'(operand_issued_i) - CRD_W'(word_pop_o);
    end
  end

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CRD_W'(`OPQ_BUF_DEPTH))
    else $error("opq_result: more words promised than buffer entries");

endmodule

// File: hdl/operand_queue.sv
`timescale 1ns/1ps
`include "opq_cfg.svh"

module operand_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  opq_pkg::opq_cmd_t cmd_i,
  input  logic              cmd_valid_i,
  input  opq_pkg::elen_t    operand_i,
  input  logic              operand_valid_i,
  input  logic              operand_issued_i,
  input  logic              operand_ready_i,
  output logic              cmd_ready_o,
  output logic              operand_queue_ready_o,
  output opq_pkg::elen_t    operand_o,
  output logic              operand_valid_o
);

  // Head command controls
  logic                 head_valid;
  opq_pkg::eew_e        head_eew;
  logic                 head_signed;
  logic [1:0]           head_widen_log;
  logic [`OPQ_VL_W-1:0] head_vl;

  logic                 word_valid;
  opq_pkg::elen_t       widened;
  logic                 cmd_pop;
  logic                 word_pop;
  logic [2:0]           select;

  opq_cmd_decode i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_pop_i   (cmd_pop),
    .cmd_ready_o (cmd_ready_o),
    .head_valid_o(head_valid),
    .eew_o       (head_eew),
    .is_signed_o (head_signed),
    .widen_log_o (head_widen_log),
    .vl_o        (head_vl)
  );

  opq_widen_exec i_exec (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .word_pop_i     (word_pop),
    .eew_i          (head_eew),
    .is_signed_i    (head_signed),
    .widen_log_i    (head_widen_log),
    .select_i       (select),
    .word_valid_o   (word_valid),
    .widened_o      (widened)
  );

  opq_result i_result (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .operand_issued_i     (operand_issued_i),
    .head_valid_i         (head_valid),
    .word_valid_i         (word_valid),
    .widened_i            (widened),
    .eew_i                (head_eew),
    .widen_log_i          (head_widen_log),
    .vl_i                 (head_vl),
    .operand_ready_i      (operand_ready_i),
    .operand_queue_ready_o(operand_queue_ready_o),
    .operand_o            (operand_o),
    .operand_valid_o      (operand_valid_o),
    .cmd_pop_o            (cmd_pop),
    .word_pop_o           (word_pop),
    .select_o             (select)
  );

endmodule

// File: dv/opq_clk_gen.sv
`timescale 1ns/1ps

module opq_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 10,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: dv/tb_operand_queue.sv
`timescale 1ns/1ps
`include "opq_cfg.svh"

module tb_operand_queue;

  localparam int          TIMEOUT = 400;
  localparam logic [31:0] SEED    = 32'h15b8_74c1;

  logic              clk;
  logic              rst_n;
  opq_pkg::opq_cmd_t cmd_i;
  logic              cmd_valid_i;
  opq_pkg::elen_t    operand_i;
  logic              operand_valid_i;
  logic              operand_issued_i;
  logic              operand_ready_i;
  logic              cmd_ready_o;
  logic              operand_queue_ready_o;
  opq_pkg::elen_t    operand_o;
  logic              operand_valid_o;

  opq_pkg::opq_cmd_t cmds[$];
  logic [63:0]       words[$];
  logic [63:0]       exp_beats[$];
  logic [31:0]       lfsr_q = SEED;
  int                tests = 0;
  int                checks = 0;
  int                errors = 0;

  opq_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  operand_queue dut0 (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .cmd_i                (cmd_i),
    .cmd_valid_i          (cmd_valid_i),
    .operand_i            (operand_i),
    .operand_valid_i      (operand_valid_i),
    .operand_issued_i     (operand_issued_i),
    .operand_ready_i      (operand_ready_i),
    .cmd_ready_o          (cmd_ready_o),
    .operand_queue_ready_o(operand_queue_ready_o),
    .operand_o            (operand_o),
    .operand_valid_o      (operand_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus data and reference model

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [63:0] rand_word();
    logic [63:0] word;
    for (int b = 0; b < 64; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      word[b] = lfsr_q[0];
    end
    return word;
  endfunction

  function automatic int factor_of(opq_pkg::conv_e conv);
    case (conv)
      opq_pkg::SEXT2, opq_pkg::ZEXT2: return 2;
      opq_pkg::SEXT4, opq_pkg::ZEXT4: return 4;
      opq_pkg::SEXT8, opq_pkg::ZEXT8: return 8;
      default:                        return 1;
    endcase
  endfunction

  // Output element e of select s is source element s*n+e, extended to w*f bits
  function automatic logic [63:0] widen_model(logic [63:0] word, int w, int f, bit sgn, int s);
    logic [63:0] res;
    int          n;
    int          src_bit;
    n = 64 / (w * f);
    res = '0;
    for (int e = 0; e < n; e++) begin
      for (int b = 0; b < w * f; b++) begin
        src_bit = (s * n + e) * w + ((b < w) ? b : w - 1);
        res[e * w * f + b] = (b < w || sgn) ? word[src_bit] : 1'b0;
      end
    end
    return res;
  endfunction

  // Queues one command with its operand words and the beats they should give
  task automatic add_cmd(opq_pkg::eew_e eew, opq_pkg::conv_e conv, int vl);
    opq_pkg::opq_cmd_t cmd;
    logic [63:0]       word;
    int                w;
    int                f;
    int                n;
    int                beats;
    int                nwords;
    bit                sgn;
    w = 8 << int'(eew);
    f = factor_of(conv);
    sgn = conv inside {opq_pkg::SEXT2, opq_pkg::SEXT4, opq_pkg::SEXT8};
    n = 64 / (w * f);
    beats = (vl + n - 1) / n;
    nwords = (beats + f - 1) / f;
    cmd.eew = eew;
    cmd.conv = conv;
    cmd.vl = 16'(vl);
    cmds.push_back(cmd);
    for (int k = 0; k < nwords; k++) begin
      word = rand_word();
      // Make sure at least one element has its top bit set
      if (f > 1) begin
        word[w - 1] = 1'b1;
      end
      words.push_back(word);
      for (int s = 0; s < f && k * f + s < beats; s++) begin
        exp_beats.push_back(widen_model(word, w, f, sgn, s));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checking and reporting

  task automatic check_eq(logic [63:0] expected, logic [63:0] actual, string what);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic abort_run(string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic report_test(string name, int errs_before);
    tests++;
    $display("%-14s finished with %0d errors", name, errors - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers and monitor

  task automatic send_cmds();
    int guard;
    foreach (cmds[i]) begin
      guard = 0;
      while (!cmd_ready_o) begin
        @(negedge clk);
        guard++;
        if (guard > TIMEOUT) begin
          abort_run("command ready");
        end
      end
      cmd_i = cmds[i];
      cmd_valid_i = 1'b1;
      @(negedge clk);
      cmd_valid_i = 1'b0;
    end
  endtask

  // Issue pulse and data in the same cycle
  task automatic drive_word(logic [63:0] word);
    int guard;
    guard = 0;
    while (!operand_queue_ready_o) begin
      @(negedge clk);
      guard++;
      if (guard > TIMEOUT) begin
        abort_run("operand credit");
      end
    end
    operand_i = word;
    operand_issued_i = 1'b1;
    operand_valid_i = 1'b1;
    @(negedge clk);
    operand_issued_i = 1'b0;
    operand_valid_i = 1'b0;
  endtask

  task automatic feed_words();
    foreach (words[i]) begin
      drive_word(words[i]);
    end
  endtask

  task automatic collect_beats(string name);
    int guard;
    operand_ready_i = 1'b1;
    foreach (exp_beats[i]) begin
      guard = 0;
      while (!operand_valid_o) begin
        @(negedge clk);
        guard++;
        if (guard > TIMEOUT) begin
          abort_run("an output beat");
        end
      end
      check_eq(exp_beats[i], operand_o, $sformatf("%s beat %0d", name, i));
      @(negedge clk);
    end
    operand_ready_i = 1'b0;
  endtask

  task automatic run_queued(string name);
    int errs_before;
    errs_before = errors;
    fork
      send_cmds();
      feed_words();
      collect_beats(name);
    join
    check_eq(64'd0, 64'(operand_valid_o), {name, " valid after last beat"});
    cmds.delete();
    words.delete();
    exp_beats.delete();
    report_test(name, errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_pass_through();
    add_cmd(opq_pkg::EW32, opq_pkg::CONV_NONE, 5);
    add_cmd(opq_pkg::EW64, opq_pkg::CONV_NONE, 4);
    run_queued("pass_through");
  endtask

  task automatic test_sign_ext();
    add_cmd(opq_pkg::EW16, opq_pkg::SEXT2, 8);
    add_cmd(opq_pkg::EW8, opq_pkg::SEXT4, 8);
    run_queued("sign_ext");
  endtask

  task automatic test_zero_ext();
    add_cmd(opq_pkg::EW32, opq_pkg::ZEXT2, 4);
    add_cmd(opq_pkg::EW8, opq_pkg::ZEXT8, 16);
    run_queued("zero_ext");
  endtask

  // First command leaves the last slice of its word unused
  task automatic test_partial_word();
    add_cmd(opq_pkg::EW8, opq_pkg::ZEXT4, 5);
    add_cmd(opq_pkg::EW16, opq_pkg::SEXT2, 3);
    run_queued("partial_word");
  endtask

  task automatic test_backpressure();
    int          errs_before;
    logic [63:0] held;
    errs_before = errors;
    add_cmd(opq_pkg::EW64, opq_pkg::CONV_NONE, 3);
    operand_ready_i = 1'b0;
    send_cmds();
    for (int k = 0; k < `OPQ_BUF_DEPTH; k++) begin
      check_eq(64'd1, 64'(operand_queue_ready_o), "credit free before issue");
      drive_word(words[k]);
    end
    check_eq(64'd0, 64'(operand_queue_ready_o), "credits exhausted");
    check_eq(64'd1, 64'(operand_valid_o), "valid with ready low");
    held = operand_o;
    repeat (4) begin
      @(negedge clk);
      check_eq(64'd1, 64'(operand_valid_o), "valid held");
      check_eq(held, operand_o, "data held");
    end
    check_eq(exp_beats[0], held, "first held beat");
    operand_ready_i = 1'b1;
    @(negedge clk);
    operand_ready_i = 1'b0;
    check_eq(64'd1, 64'(operand_queue_ready_o), "credit returned after beat");
    // Remaining word and beats go through the normal path
    for (int k = 0; k < `OPQ_BUF_DEPTH; k++) begin
      void'(words.pop_front());
    end
    void'(exp_beats.pop_front());
    cmds.delete();
    fork
      feed_words();
      collect_beats("backpressure");
    join
    check_eq(64'd0, 64'(operand_valid_o), "backpressure valid after last beat");
    words.delete();
    exp_beats.delete();
    report_test("backpressure", errs_before);
  endtask

  initial begin
    int guard;
    cmd_i = '0;
    cmd_valid_i = 1'b0;
    operand_i = '0;
    operand_valid_i = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i = 1'b0;
    guard = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      guard++;
      if (guard > TIMEOUT) begin
        abort_run("reset release");
      end
    end
    @(negedge clk);
    check_eq(64'd0, 64'(operand_valid_o), "valid after reset");
    check_eq(64'd1, 64'(cmd_ready_o), "command ready after reset");
    check_eq(64'd1, 64'(operand_queue_ready_o), "operand ready after reset");
    test_pass_through();
    test_sign_ext();
    test_zero_ext();
    test_partial_word();
    test_backpressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+hdl
hdl/opq_pkg.sv
hdl/opq_fifo.sv
hdl/opq_cmd_decode.sv
hdl/opq_widen_exec.sv
hdl/opq_result.sv
hdl/operand_queue.sv
dv/opq_clk_gen.sv
dv/tb_operand_queue.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_operand_queue -f all.f -o tb_operand_queue_sim

output=$(./obj_dir/tb_operand_queue_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
